// ==== hdl/csr_pkg.sv ====
// ===================================================================
// CSR package
// Addresses, bit positions, reset values and shared types of the
// machine-mode CSR block for a small RV32I core
// ===================================================================
package csr_pkg;

    localparam int XLEN       = 32;  // Data width
    localparam int CSR_ADDR_W = 12;  // CSR address width

    // ===============================================================
    // Machine register addresses
    // ===============================================================
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS       = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA          = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE           = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC         = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUSH      = 12'h310;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCOUNTINHIBIT = 12'h320;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH      = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC          = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE        = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL         = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP           = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTINST        = 12'h34A;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL2        = 12'h34B;  // Reads as zero

    // Counters, low and high halves
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE        = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET      = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH       = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH     = 12'hB82;

    // Identity registers, all zero
    localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID     = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID       = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID        = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID       = 12'hF14;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCONFIGPTR    = 12'hF15;

    // Custom trap entry and exit
    localparam logic [CSR_ADDR_W-1:0] CSR_ENTER_TRAP    = 12'hFC0;
    localparam logic [CSR_ADDR_W-1:0] CSR_EXIT_TRAP     = 12'hFC1;

    // ===============================================================
    // Bit positions and codes
    // ===============================================================
    localparam int MSTATUS_MIE_BIT  = 3;   // Global interrupt enable
    localparam int MSTATUS_MPIE_BIT = 7;   // MIE saved on trap entry
    localparam int MCAUSE_INT_BIT   = 31;  // Set for interrupt causes

    // Interrupt bit in mip/mie, same value as the cause code
    localparam logic [4:0] IRQ_SOFTWARE = 5'd3;
    localparam logic [4:0] IRQ_TIMER    = 5'd7;
    localparam logic [4:0] IRQ_EXTERNAL = 5'd11;

    localparam int CNT_CYCLE   = 0;  // mcountinhibit.CY
    localparam int CNT_INSTRET = 2;  // mcountinhibit.IR

    localparam logic [XLEN-1:0] MISA_RESET  = 32'h4000_0100;  // RV32, I only
    localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0003;  // Mode 11, not set

    localparam logic [1:0] MTVEC_DIRECT   = 2'd0;
    localparam logic [1:0] MTVEC_VECTORED = 2'd1;

    // ===============================================================
    // Shared types
    // ===============================================================
    typedef struct packed {
        logic [CSR_ADDR_W-1:0] addr;   // CSR address
        logic [XLEN-1:0]       wdata;  // Write data
        logic                  we;     // 1 for write
    } csr_req_t;

    typedef struct packed {
        logic [63:0] mcycle;
        logic [63:0] minstret;
    } csr_counts_t;

    typedef struct packed {
        logic [XLEN-3:0] base;  // Word-aligned handler base
        logic [1:0]      mode;
    } mtvec_fields_t;

    // mtvec seen as stored word or as base/mode
    typedef union packed {
        logic [XLEN-1:0] raw;
        mtvec_fields_t   fields;
    } mtvec_u;

endpackage

// ==== hdl/csr_bus_slave.sv ====
// ===================================================================
// CSR bus slave
// Accepts one Wishbone classic request at a time, hands it to the
// register block and holds ack or err until the strobe falls
// ===================================================================
module csr_bus_slave import csr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stb_i,
    input  logic                  cyc_i,
    input  logic                  we_i,
    input  logic [CSR_ADDR_W-1:0] addr_i,
    input  logic [XLEN-1:0]       data_i,
    input  logic                  hit_i,        // Address decoded by register block
    output logic                  req_valid_o,  // One cycle per accepted request
    output csr_req_t              req_o,
    output logic                  ack_o,
    output logic                  err_o
);

    logic ack_q;  // Registered completion flags
    logic err_q;

    // New request only while no response is showing
    assign req_valid_o = stb_i & cyc_i & ~ack_o & ~err_o;

    assign req_o.addr  = addr_i;
    assign req_o.wdata = data_i;
    assign req_o.we    = we_i;

    // Response drops in the same cycle as the strobe
    assign ack_o = ack_q & stb_i;
    assign err_o = err_q & stb_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else if (req_valid_o) begin
            ack_q <= hit_i;   // Known register
            err_q <= ~hit_i;  // Unsupported address
        end else begin
            // Hold while strobe stays high
            ack_q <= ack_q & stb_i;
            err_q <= err_q & stb_i;
        end
    end

endmodule

// ==== hdl/csr_machine_regs.sv ====
// ===================================================================
// Machine registers
// Holds the M-mode CSRs, decodes and serves bus accesses, latches
// pending interrupts and runs the custom trap entry and exit
// ===================================================================
module csr_machine_regs import csr_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            req_valid_i,
    input  csr_req_t        req_i,
    output logic            hit_o,            // Address is a known CSR
    output logic [XLEN-1:0] data_o,           // Registered read data
    input  csr_counts_t     counts_i,
    output logic [1:0]      inhibit_o,        // {IR, CY}
    input  logic [XLEN-1:0] io_interrupts_i,
    output logic [XLEN-1:0] io_interrupts_o   // Pending, filtered by MIE
);

    logic [XLEN-1:0] misa, mstatus, mstatush, mie, mip;
    logic [XLEN-1:0] mepc, mcause, mtval, mtinst, mscratch, mcountinhibit;
    mtvec_u          mtvec;

    logic            mtvec_set;    // Mode 00 or 01
    logic            irq_cause;    // mcause is a known interrupt
    logic [XLEN-1:0] trap_base;
    logic [XLEN-1:0] trap_target;
    logic [XLEN-1:0] rdata;
    logic            trap_access;

    assign inhibit_o       = {mcountinhibit[CNT_INSTRET], mcountinhibit[CNT_CYCLE]};
    assign io_interrupts_o = mstatus[MSTATUS_MIE_BIT] ? mip : '0;

    // ===============================================================
    // Trap target from mtvec and mcause
    // ===============================================================
    assign mtvec_set = ~mtvec.fields.mode[1];
    assign irq_cause = mcause[MCAUSE_INT_BIT] && (mcause[XLEN-2:5] == '0) &&
                       (mcause[4:0] inside {IRQ_SOFTWARE, IRQ_TIMER, IRQ_EXTERNAL});
    assign trap_base = {mtvec.fields.base, 2'b00};

    // Vectored interrupts land at base + 4 * code
    assign trap_target = (mtvec.fields.mode == MTVEC_VECTORED && irq_cause) ?
                         trap_base + {25'b0, mcause[4:0], 2'b00} : trap_base;

    assign trap_access = (req_i.addr == CSR_ENTER_TRAP) || (req_i.addr == CSR_EXIT_TRAP);

    // ===============================================================
    // Address decode and read mux
    // ===============================================================
    always_comb begin
        hit_o = 1'b1;
        rdata = '0;
        case (req_i.addr)
            CSR_MISA:          rdata = misa;
            CSR_MSTATUS:       rdata = mstatus;
            CSR_MSTATUSH:      rdata = mstatush;
            CSR_MIE:           rdata = mie;
            CSR_MIP:           rdata = mip;
            CSR_MTVEC:         rdata = mtvec.raw;
            CSR_MEPC:          rdata = mepc;
            CSR_MCAUSE:        rdata = mcause;
            CSR_MTVAL:         rdata = mtval;
            CSR_MTINST:        rdata = mtinst;
            CSR_MSCRATCH:      rdata = mscratch;
            CSR_MCOUNTINHIBIT: rdata = mcountinhibit;
            CSR_MCYCLE:        rdata = counts_i.mcycle[31:0];
            CSR_MCYCLEH:       rdata = counts_i.mcycle[63:32];
            CSR_MINSTRET:      rdata = counts_i.minstret[31:0];
            CSR_MINSTRETH:     rdata = counts_i.minstret[63:32];
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
            CSR_MHARTID, CSR_MCONFIGPTR, CSR_MTVAL2: begin
                rdata = '0;  // Not implemented, zero
            end
            CSR_ENTER_TRAP:    rdata = mtvec_set ? trap_target : mtvec.raw;
            CSR_EXIT_TRAP:     rdata = mepc;
            default:           hit_o = 1'b0;
        endcase
    end

    // Read data, also returned by trap accesses on a write
    always_ff @(posedge clk_i) begin
        if (req_valid_i && (!req_i.we || trap_access)) begin
            data_o <= rdata;
        end
    end

    // ===============================================================
    // Register state
    // ===============================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            misa          <= MISA_RESET;
            mstatus       <= '0;  // MIE off
            mstatush      <= '0;
            mie           <= '0;
            mip           <= '0;
            mtvec.raw     <= MTVEC_RESET;
            mepc          <= '0;
            mcause        <= '0;
            mtval         <= '0;
            mtinst        <= '0;
            mscratch      <= '0;
            mcountinhibit <= '0;  // All counters run
        end else begin
            // New enabled interrupts, overridden below by bus or trap
            if (mstatus[MSTATUS_MIE_BIT]) begin
                mip <= mip | (io_interrupts_i & mie);
            end

            if (req_valid_i && req_i.we) begin
                case (req_i.addr)
                    CSR_MISA:          misa          <= req_i.wdata;
                    CSR_MSTATUS:       mstatus       <= req_i.wdata;
                    CSR_MSTATUSH:      mstatush      <= req_i.wdata;
                    CSR_MIE:           mie           <= req_i.wdata;
                    CSR_MIP:           mip           <= req_i.wdata;
                    CSR_MTVEC:         mtvec.raw     <= req_i.wdata;
                    CSR_MEPC:          mepc          <= req_i.wdata;
                    CSR_MCAUSE:        mcause        <= req_i.wdata;
                    CSR_MTVAL:         mtval         <= req_i.wdata;
                    CSR_MTINST:        mtinst        <= req_i.wdata;
                    CSR_MSCRATCH:      mscratch      <= req_i.wdata;
                    CSR_MCOUNTINHIBIT: mcountinhibit <= req_i.wdata;
                    default: ;  // Counters and identity regs ignore writes
                endcase
            end

            if (req_valid_i && req_i.addr == CSR_ENTER_TRAP) begin
                if (mtvec_set) begin
                    // Save MIE, block nested interrupts
                    mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                    mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
                end else if (irq_cause) begin
                    mip[mcause[4:0]] <= 1'b0;  // Drop the pending bit
                end
            end

            if (req_valid_i && req_i.addr == CSR_EXIT_TRAP) begin
                mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
                mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/csr_counters.sv ====
// ===================================================================
// Machine counters
// 64-bit mcycle and minstret, each stopped by its mcountinhibit bit
// ===================================================================
module csr_counters import csr_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        instret_i,  // One pulse per retired instruction
    input  logic [1:0]  inhibit_i,  // {IR, CY}
    output csr_counts_t counts_o
);

    logic cycle_en;
    logic instret_en;

    // Bit 1 carries mcountinhibit bit 2
    assign cycle_en   = ~inhibit_i[0];
    assign instret_en = instret_i & ~inhibit_i[1];

    // ===============================================================
    // Counter update
    // ===============================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            counts_o <= '0;
        end else begin
            if (cycle_en) begin
                counts_o.mcycle <= counts_o.mcycle + 64'd1;  // Every clock
            end
            if (instret_en) begin
                counts_o.minstret <= counts_o.minstret + 64'd1;
            end
        end
    end

endmodule

// ==== hdl/csr_unit.sv ====
// ===================================================================
// CSR unit
// Machine-mode CSR block on a Wishbone classic bus, built from the
// bus slave, the register block and the counters
// ===================================================================
module csr_unit import csr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Wishbone classic
    input  logic [CSR_ADDR_W-1:0] addr_i,
    input  logic [XLEN-1:0]       data_i,
    input  logic                  stb_i,
    input  logic                  cyc_i,
    input  logic                  we_i,
    output logic                  ack_o,
    output logic                  err_o,
    output logic [XLEN-1:0]       data_o,
    // Core side
    input  logic                  instret_i,
    input  logic [XLEN-1:0]       io_interrupts_i,
    output logic [XLEN-1:0]       io_interrupts_o
);

    logic        req_valid;
    csr_req_t    req;
    logic        hit;
    csr_counts_t counts;
    logic [1:0]  inhibit;

    csr_bus_slave u_bus (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stb_i       (stb_i),
        .cyc_i       (cyc_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .data_i      (data_i),
        .hit_i       (hit),
        .req_valid_o (req_valid),
        .req_o       (req),
        .ack_o       (ack_o),
        .err_o       (err_o)
    );

    csr_machine_regs u_regs (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .hit_o           (hit),
        .data_o          (data_o),
        .counts_i        (counts),
        .inhibit_o       (inhibit),
        .io_interrupts_i (io_interrupts_i),
        .io_interrupts_o (io_interrupts_o)
    );

    csr_counters u_counters (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .instret_i (instret_i),
        .inhibit_i (inhibit),
        .counts_o  (counts)
    );

endmodule

// ==== test/csr_unit_props.sv ====
// ===================================================================
// CSR unit properties
// Bus response and interrupt filter assertions, bound into the DUT
// ===================================================================
module csr_unit_props import csr_pkg::*; (
    input logic            clk_i,
    input logic            rst_i,
    input logic            stb_i,
    input logic            ack_i,
    input logic            err_i,
    input logic            mie_i,  // mstatus.MIE
    input logic [XLEN-1:0] irq_i   // Filtered pending word
);

    a_one_resp: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_i && err_i))
        else $error("ack and err high in the same cycle");

    // Response masked by the strobe
    a_resp_stb: assert property (@(posedge clk_i) disable iff (rst_i) (ack_i || err_i) |-> stb_i)
        else $error("response seen without strobe");

    a_irq_mask: assert property (@(posedge clk_i) disable iff (rst_i) !mie_i |-> irq_i == '0)
        else $error("pending interrupts shown while MIE is clear");

endmodule

bind csr_unit csr_unit_props u_props (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .stb_i (stb_i),
    .ack_i (ack_o),
    .err_i (err_o),
    .mie_i (u_regs.mstatus[csr_pkg::MSTATUS_MIE_BIT]),
    .irq_i (io_interrupts_o)
);

// ==== test/csr_unit_tb.sv ====
// ===================================================================
// CSR unit testbench
// Table-driven bus accesses, then counter, interrupt and trap
// sequences against values taken from the CSR rules
// ===================================================================
module csr_unit_tb import csr_pkg::*; ();

    logic                  clk_i;
    logic                  rst_i;
    logic [CSR_ADDR_W-1:0] addr_i;
    logic [XLEN-1:0]       data_i;
    logic                  stb_i, cyc_i, we_i;
    logic                  ack_o, err_o;
    logic [XLEN-1:0]       data_o;
    logic                  instret_i;
    logic [XLEN-1:0]       io_interrupts_i, io_interrupts_o;

    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
        logic                  exp_err;    // Unsupported address
        logic [XLEN-1:0]       exp_rdata;
        logic                  chk;        // Compare read data
    } stim_t;

    stim_t       stim_q[$];
    int          errors = 0;
    logic [31:0] seed = 32'd56;  // LCG state

    csr_unit dut (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_entry(input logic we, input logic [CSR_ADDR_W-1:0] addr,
                             input logic [XLEN-1:0] wdata, input logic exp_err,
                             input logic [XLEN-1:0] exp_rdata, input logic chk);
        stim_q.push_back('{we, addr, wdata, exp_err, exp_rdata, chk});
    endtask

    // Write followed by a read-back of the same value
    task automatic add_rw(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] value);
        add_entry(1'b1, addr, value, 1'b0, '0, 1'b0);
        add_entry(1'b0, addr, '0, 1'b0, value, 1'b1);
    endtask

    // ===============================================================
    // Bus access, called 1 unit after a rising edge
    // ===============================================================
    task automatic bus_xfer(input logic we, input logic [CSR_ADDR_W-1:0] addr,
                            input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata,
                            output logic ack, output logic err);
        int cnt;
        addr_i = addr;
        data_i = wdata;
        we_i   = we;
        stb_i  = 1'b1;
        cyc_i  = 1'b1;
        cnt    = 0;
        do begin
            @(posedge clk_i);
            #1;
            cnt++;
        end while (!ack_o && !err_o && cnt < 20);
        ack   = ack_o;
        err   = err_o;
        rdata = data_o;
        if (!ack && !err) begin
            $display("Bus timeout at %0t: no ack or err for address %h", $time, addr);
            errors++;
        end
        stb_i = 1'b0;
        cyc_i = 1'b0;
        we_i  = 1'b0;
        @(posedge clk_i);  // Lets the held response clear
        #1;
    endtask

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] value);
        logic [XLEN-1:0] rd;
        logic            ack, err;
        bus_xfer(1'b1, addr, value, rd, ack, err);
        if (!ack) begin
            $display("** Error at %0t: write to %h not acknowledged", $time, addr);
            errors++;
        end
    endtask

    task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [XLEN-1:0] value);
        logic ack, err;
        bus_xfer(1'b0, addr, '0, value, ack, err);
        if (!ack) begin
            $display("** Error at %0t: read of %h not acknowledged", $time, addr);
            errors++;
        end
    endtask

    task automatic expect_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic pulse_instret(input int count);
        repeat (count) begin
            instret_i = 1'b1;   // High for exactly one edge
            @(posedge clk_i);
            #1;
            instret_i = 1'b0;
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic pulse_irq(input logic [4:0] idx);
        io_interrupts_i = 32'h1 << idx;
        @(posedge clk_i);
        #1;
        io_interrupts_i = '0;
    endtask

    task automatic wait_irq(input logic [31:0] exp);
        int cnt;
        cnt = 0;
        while (io_interrupts_o !== exp && cnt < 10) begin
            @(posedge clk_i);
            #1;
            cnt++;
        end
        expect_word("io_interrupts_o", io_interrupts_o, exp);
    endtask

    task automatic apply_reset();
        rst_i = 1'b1;
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
    endtask

    // ===============================================================
    // Main sequence
    // ===============================================================
    initial begin
        stim_t           e;
        logic [XLEN-1:0] rd, c0, c1;
        logic            ack, err;
        int              n;
        clk_i           = 1'b0;
        rst_i           = 1'b1;
        addr_i          = '0;
        data_i          = '0;
        stb_i           = 1'b0;
        cyc_i           = 1'b0;
        we_i            = 1'b0;
        instret_i       = 1'b0;
        io_interrupts_i = '0;
        apply_reset();

        add_entry(1'b0, CSR_MISA, '0, 1'b0, 32'h4000_0100, 1'b1);  // RV32I
        add_entry(1'b0, CSR_MSTATUS, '0, 1'b0, 32'h0, 1'b1);
        add_entry(1'b0, CSR_MTVEC, '0, 1'b0, 32'h3, 1'b1);         // Not set
        add_entry(1'b0, CSR_MVENDORID, '0, 1'b0, 32'h0, 1'b1);
        add_entry(1'b0, CSR_MARCHID, '0, 1'b0, 32'h0, 1'b1);
        add_entry(1'b0, CSR_MIMPID, '0, 1'b0, 32'h0, 1'b1);
        add_entry(1'b0, CSR_MHARTID, '0, 1'b0, 32'h0, 1'b1);
        add_entry(1'b0, CSR_MCONFIGPTR, '0, 1'b0, 32'h0, 1'b1);
        add_entry(1'b0, CSR_MTVAL2, '0, 1'b0, 32'h0, 1'b1);
        add_rw(CSR_MSCRATCH, 32'hDEAD_BEEF);
        add_rw(CSR_MEPC, 32'h0000_1234);
        add_rw(CSR_MCAUSE, 32'h8000_000B);
        add_rw(CSR_MTVAL, 32'hA5A5_5A5A);
        add_rw(CSR_MTINST, 32'h0000_0073);
        add_rw(CSR_MIE, 32'h0000_0888);
        add_rw(CSR_MSTATUSH, 32'h0000_0030);
        add_entry(1'b0, 12'h140, '0, 1'b1, '0, 1'b0);  // Unsupported, err only

        foreach (stim_q[i]) begin
            e = stim_q[i];
            bus_xfer(e.we, e.addr, e.wdata, rd, ack, err);
            if (err !== e.exp_err || ack !== !e.exp_err) begin
                $display("** Error at %0t: address %h gave ack %b err %b, expected err %b",
                         $time, e.addr, ack, err, e.exp_err);
                errors++;
            end
            if (e.chk && rd !== e.exp_rdata) begin
                $display("** Error at %0t: address %h read %h, expected %h",
                         $time, e.addr, rd, e.exp_rdata);
                errors++;
            end
        end

        // Counters
        csr_write(CSR_MCOUNTINHIBIT, 32'h1);  // Stop mcycle
        csr_read(CSR_MCYCLE, c0);
        csr_write(CSR_MCYCLE, 32'h1234_5678);  // Ignored
        csr_read(CSR_MCYCLE, c1);
        expect_word("mcycle while inhibited", c1, c0);
        csr_read(CSR_MCYCLEH, rd);
        expect_word("mcycleh", rd, 32'h0);
        seed = lcg_next(seed);
        n    = int'((seed >> 16) % 32'd15) + 1;
        pulse_instret(n);
        csr_read(CSR_MINSTRET, rd);
        expect_word("minstret after pulses", rd, n);  // Counted from reset
        csr_write(CSR_MCOUNTINHIBIT, 32'h5);  // Stop minstret as well
        pulse_instret(n);
        csr_read(CSR_MINSTRET, rd);
        expect_word("minstret while inhibited", rd, n);

        // Interrupts, MIE clear then set
        csr_write(CSR_MIE, 32'h80);
        pulse_irq(IRQ_TIMER);
        expect_word("io_interrupts_o with MIE clear", io_interrupts_o, 32'h0);
        csr_read(CSR_MIP, rd);
        expect_word("mip with MIE clear", rd, 32'h0);  // Nothing latched
        csr_write(CSR_MSTATUS, 32'h8);
        pulse_irq(IRQ_TIMER);
        wait_irq(32'h80);
        csr_read(CSR_MIP, rd);
        expect_word("mip", rd, 32'h80);

        // Trap entry and exit
        csr_write(CSR_MTVEC, 32'h101);  // Base 0x100, vectored
        csr_write(CSR_MEPC, 32'h2000);
        csr_write(CSR_MCAUSE, 32'h8000_0007);
        csr_read(CSR_ENTER_TRAP, rd);
        expect_word("vectored trap target", rd, 32'h11C);  // 0x100 + 4 x 7
        expect_word("io_interrupts_o in trap", io_interrupts_o, 32'h0);
        csr_read(CSR_EXIT_TRAP, rd);
        expect_word("trap return address", rd, 32'h2000);
        expect_word("io_interrupts_o after exit", io_interrupts_o, 32'h80);
        csr_write(CSR_MTVEC, 32'h100);  // Direct
        csr_read(CSR_ENTER_TRAP, rd);
        expect_word("direct trap target", rd, 32'h100);

        // Unset mtvec after a fresh reset
        apply_reset();
        csr_write(CSR_MIE, 32'h80);
        csr_write(CSR_MSTATUS, 32'h8);
        pulse_irq(IRQ_TIMER);
        wait_irq(32'h80);
        csr_write(CSR_MCAUSE, 32'h8000_0007);
        csr_read(CSR_ENTER_TRAP, rd);
        expect_word("trap with unset mtvec", rd, 32'h3);
        csr_read(CSR_MIP, rd);
        expect_word("mip after unset trap", rd, 32'h0);
        csr_read(CSR_MSTATUS, rd);
        expect_word("mstatus.MIE after unset trap", {31'b0, rd[MSTATUS_MIE_BIT]}, 32'h1);

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
hdl/csr_pkg.sv
hdl/csr_bus_slave.sv
hdl/csr_machine_regs.sv
hdl/csr_counters.sv
hdl/csr_unit.sv
test/csr_unit_props.sv
test/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module csr_unit_tb -f csr_unit.f -o csr_unit_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/csr_unit_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
